// ==== source/hypercubePkg.sv ====
package hypercubePkg;

    // a graph is a subset of the vertices of the 7-dimensional hypercube
    localparam int vertexCount = 128;

    // every vertex has one neighbour per dimension
    localparam int cubeDim = 7;

    // the graph arrives as four 32-bit beats, lowest vertices first
    localparam int wordWidth = 32;
    localparam int wordsPerGraph = 4;

    // up to 64 singletons fit in the cube (all even-parity vertices), so 7 bits are needed
    localparam int countWidth = 7;

    // cycles from the eliminator input to a valid singleton count
    // one cycle for the neighbour check and five for the population count
    localparam int countLatency = 6;

    // bit i is set when vertex i is part of the graph
    typedef logic [vertexCount-1:0] graphMask;

    // one assembled graph, valid for a single cycle
    typedef struct packed {
        logic     valid;
        graphMask graph;
    } graphItem;

    // the split graph as it leaves the front end
    typedef struct packed {
        logic                  valid;
        graphMask              nonSingletons;
        logic [countWidth-1:0] singletonCount;
    } resultItem;

endpackage

// ==== source/graphCapture.sv ====
module graphCapture import hypercubePkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [wordWidth-1:0] wordIn,
    input  logic                 wordValid,
    input  logic                 wordFirst,
    output graphItem             graphOut
);

    // index of the next beat within the current graph
    logic [1:0] beatCount;
    // set between a wordFirst beat and the last beat of that graph
    logic framed;
    // one-cycle strobe after the last beat has been taken in
    logic graphReady;
    // received words, the newest one enters at the top
    graphMask shiftWords;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            beatCount <= '0;
            framed <= 1'b0;
            graphReady <= 1'b0;
        end else begin
            graphReady <= 1'b0;
            if (wordValid && wordFirst) begin
                // a first beat always restarts assembly, even in the middle of a graph
                beatCount <= 2'd1;
                framed <= 1'b1;
            end else if (wordValid && framed) begin
                beatCount <= beatCount + 2'd1;
                if (beatCount == 2'(wordsPerGraph - 1)) begin
                    // last beat, so stop framing until the next wordFirst
                    framed <= 1'b0;
                    graphReady <= 1'b1;
                end
            end
        end
    end

    // after four shifts the first beat sits in bits 31:0 and the last one in bits 127:96
    // stray beats outside a frame are not taken in
    always_ff @(posedge clk) begin
        if (wordValid && (wordFirst || framed)) begin
            shiftWords <= {wordIn, shiftWords[vertexCount-1:wordWidth]};
        end
    end

    // the words stay put while the strobe is high, since the next first beat comes later
    assign graphOut = '{valid: graphReady, graph: shiftWords};

endmodule

// ==== source/neighborDetect.sv ====
module neighborDetect import hypercubePkg::*; (
    input  logic     clk,
    input  graphMask graph,
    output graphMask hasNeighbor
);

    // unregistered OR of all neighbours of each vertex
    graphMask anyNeighbor;

    for (genvar v = 0; v < vertexCount; v++) begin : gVertex
        // one bit per dimension, taken from the vertex whose index differs in that bit
        logic [cubeDim-1:0] neighborBits;

        for (genvar d = 0; d < cubeDim; d++) begin : gDim
            // flipping bit d of the index gives the neighbour along dimension d
            assign neighborBits[d] = graph[v ^ (1 << d)];
        end

        // vertex v sees a present neighbour when any of its seven neighbours is set
        assign anyNeighbor[v] = |neighborBits;
    end

    // note that presence of v itself is not checked here
    // the eliminator masks the result with the delayed graph
    always_ff @(posedge clk) begin
        hasNeighbor <= anyNeighbor;
    end

endmodule

// ==== source/singletonCounter.sv ====
module singletonCounter import hypercubePkg::*; (
    input  logic                  clk,
    input  graphMask              singletons,
    output logic [countWidth-1:0] singletonCount
);

    // one bit per vertex pair that differs only in index bit 0
    logic [vertexCount/2-1:0] pairAny;
    // singletons per group of four pairs, which is one 3-subcube
    logic [2:0] quadSum [vertexCount/8];
    // sums over two 3-subcubes, at most 8
    logic [3:0] sumB [vertexCount/16];
    // sums over eight 3-subcubes, at most 32
    logic [5:0] sumC [2];

    // two neighbours can never both be singletons, so each pair holds at most one
    // an OR therefore counts the pair exactly
    always_ff @(posedge clk) begin
        for (int p = 0; p < vertexCount / 2; p++) begin
            pairAny[p] <= singletons[2*p] | singletons[2*p+1];
        end
    end

    // four pairs span a 3-subcube, which can hold four non-adjacent vertices
    // so all four pair bits may be set and the subsum needs 3 bits
    // a lookup table keeps this stage small
    always_ff @(posedge clk) begin
        for (int q = 0; q < vertexCount / 8; q++) begin
            case (pairAny[4*q +: 4])
                4'b0000: quadSum[q] <= 3'd0;
                4'b0001: quadSum[q] <= 3'd1;
                4'b0010: quadSum[q] <= 3'd1;
                4'b0011: quadSum[q] <= 3'd2;
                4'b0100: quadSum[q] <= 3'd1;
                4'b0101: quadSum[q] <= 3'd2;
                4'b0110: quadSum[q] <= 3'd2;
                4'b0111: quadSum[q] <= 3'd3;
                4'b1000: quadSum[q] <= 3'd1;
                4'b1001: quadSum[q] <= 3'd2;
                4'b1010: quadSum[q] <= 3'd2;
                4'b1011: quadSum[q] <= 3'd3;
                4'b1100: quadSum[q] <= 3'd2;
                4'b1101: quadSum[q] <= 3'd3;
                4'b1110: quadSum[q] <= 3'd3;
                default: quadSum[q] <= 3'd4;
            endcase
        end
    end

    // first adder level, sixteen subsums down to eight
    always_ff @(posedge clk) begin
        for (int b = 0; b < vertexCount / 16; b++) begin
            sumB[b] <= quadSum[2*b] + quadSum[2*b+1];
        end
    end

    // four-input adders take eight sums down to two
    // this keeps the whole counter at five register stages
    always_ff @(posedge clk) begin
        for (int c = 0; c < 2; c++) begin
            sumC[c] <= sumB[4*c] + sumB[4*c+1] + sumB[4*c+2] + sumB[4*c+3];
        end
    end

    // final sum, which reaches 64 for the full set of even-parity vertices
    always_ff @(posedge clk) begin
        singletonCount <= sumC[0] + sumC[1];
    end

endmodule

// ==== source/singletonEliminator.sv ====
module singletonEliminator import hypercubePkg::*; (
    input  logic                  clk,
    input  graphMask              graph,
    output graphMask              nonSingletons,
    output logic [countWidth-1:0] singletonCount
);

    // neighbour flags, one cycle after the graph
    graphMask hasNeighbor;
    // graph delayed to line up with the neighbour flags
    graphMask graphD;
    // present vertices without any present neighbour
    graphMask singletons;

    neighborDetect neighborCheck (
        .clk         (clk),
        .graph       (graph),
        .hasNeighbor (hasNeighbor)
    );

    always_ff @(posedge clk) begin
        graphD <= graph;
    end

    // a present vertex is either a singleton or a non-singleton, never both
    assign singletons = graphD & ~hasNeighbor;

    // the non-singleton mask goes on to the component search
    // it is ready two cycles after the graph
    always_ff @(posedge clk) begin
        nonSingletons <= graphD & hasNeighbor;
    end

    // the counter adds five more cycles, so the count lands at cycle 6
    singletonCounter popCount (
        .clk            (clk),
        .singletons     (singletons),
        .singletonCount (singletonCount)
    );

endmodule

// ==== source/resultAlign.sv ====
module resultAlign import hypercubePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  graphValid,
    input  graphMask              nonSingletons,
    input  logic [countWidth-1:0] singletonCount,
    output resultItem             result
);

    // valid strobe travelling alongside the graph until the count is ready
    logic [countLatency-1:0] validDelay;
    // the mask arrives at cycle 2, so it waits countLatency - 2 more cycles
    graphMask maskDelay [countLatency-2];

    // output registers
    logic                  validQ;
    graphMask              maskQ;
    logic [countWidth-1:0] countQ;

    // one bit per cycle in flight, so graphs can follow back to back
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validDelay <= '0;
        end else begin
            validDelay <= {validDelay[countLatency-2:0], graphValid};
        end
    end

    always_ff @(posedge clk) begin
        maskDelay[0] <= nonSingletons;
        for (int s = 1; s < countLatency - 2; s++) begin
            maskDelay[s] <= maskDelay[s-1];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= validDelay[countLatency-1];
        end
    end

    // the last delay stages of mask and count now belong to the same graph
    always_ff @(posedge clk) begin
        maskQ <= maskDelay[countLatency-3];
        countQ <= singletonCount;
    end

    assign result = '{
        valid:          validQ,
        nonSingletons:  maskQ,
        singletonCount: countQ
    };

endmodule

// ==== source/singletonEliminationTop.sv ====
module singletonEliminationTop import hypercubePkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [wordWidth-1:0] wordIn,
    input  logic                 wordValid,
    input  logic                 wordFirst,
    output resultItem            result
);

    // assembled graph with its one-cycle strobe
    graphItem graphIn;
    // processing results, mask at cycle 2 and count at cycle 6
    graphMask nonSingletons;
    logic [countWidth-1:0] singletonCount;

    graphCapture capture (
        .clk       (clk),
        .rstN      (rstN),
        .wordIn    (wordIn),
        .wordValid (wordValid),
        .wordFirst (wordFirst),
        .graphOut  (graphIn)
    );

    // the eliminator is a plain pipeline and ignores the strobe
    singletonEliminator eliminator (
        .clk            (clk),
        .graph          (graphIn.graph),
        .nonSingletons  (nonSingletons),
        .singletonCount (singletonCount)
    );

    // the strobe bypasses the eliminator and is realigned here
    resultAlign align (
        .clk            (clk),
        .rstN           (rstN),
        .graphValid     (graphIn.valid),
        .nonSingletons  (nonSingletons),
        .singletonCount (singletonCount),
        .result         (result)
    );

endmodule

// ==== tb/singletonElimTb.sv ====
module singletonElimTb import hypercubePkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int halfPeriod = 50;
    // inputs change this long after each rising edge
    localparam int driveDelay = 10;
    // edges from the drive of the last beat to the first sample with result.valid high
    localparam int expectedLatency = 8;
    localparam int resultTimeout = 40;

    logic                 clk;
    logic                 rstN;
    logic [wordWidth-1:0] wordIn;
    logic                 wordValid;
    logic                 wordFirst;
    resultItem            result;

    // rising edges seen so far
    int unsigned cycleCount;
    string testName;

    // expected results in the order in which their graphs were sent
    graphMask    expMaskQ[$];
    int          expCountQ[$];
    int unsigned expCycleQ[$];
    string       expNameQ[$];

    singletonEliminationTop uut (
        .clk       (clk),
        .rstN      (rstN),
        .wordIn    (wordIn),
        .wordValid (wordValid),
        .wordFirst (wordFirst),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic stopRun();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // a present vertex keeps its place when one of its index bit flips is present too
    function automatic graphMask modelNonSingletons(graphMask g);
        graphMask keep;
        keep = '0;
        for (int v = 0; v < vertexCount; v++) begin
            for (int d = 0; d < cubeDim; d++) begin
                if (g[v] && g[v ^ (1 << d)]) begin
                    keep[v] = 1'b1;
                end
            end
        end
        return keep;
    endfunction

    // lone vertices are present ones with none of the seven neighbours present
    function automatic int modelSingletonCount(graphMask g);
        int count;
        logic lone;
        count = 0;
        for (int v = 0; v < vertexCount; v++) begin
            lone = g[v];
            for (int d = 0; d < cubeDim; d++) begin
                if (g[v ^ (1 << d)]) begin
                    lone = 1'b0;
                end
            end
            if (lone) begin
                count++;
            end
        end
        return count;
    endfunction

    // sparse enough to leave a few lone vertices among the pairs and clusters
    function automatic graphMask randomGraph();
        graphMask g;
        for (int w = 0; w < wordsPerGraph; w++) begin
            g[w*wordWidth +: wordWidth] = $urandom() & $urandom();
        end
        return g;
    endfunction

    task automatic driveBeat(logic [wordWidth-1:0] word, logic first);
        @(posedge clk);
        #driveDelay;
        wordIn = word;
        wordValid = 1'b1;
        wordFirst = first;
    endtask

    task automatic driveIdle();
        @(posedge clk);
        #driveDelay;
        wordIn = '0;
        wordValid = 1'b0;
        wordFirst = 1'b0;
    endtask

    // lowest vertices go first, and only the first beat carries wordFirst
    task automatic sendBeats(graphMask g);
        for (int w = 0; w < wordsPerGraph; w++) begin
            driveBeat(g[w*wordWidth +: wordWidth], w == 0);
        end
    endtask

    // called right after the last beat was driven, so cycleCount is the drive edge
    task automatic sendKnown(graphMask g, graphMask mask, int count, string name);
        sendBeats(g);
        expMaskQ.push_back(mask);
        expCountQ.push_back(count);
        expCycleQ.push_back(cycleCount + expectedLatency);
        expNameQ.push_back(name);
    endtask

    task automatic sendGraph(graphMask g, string name);
        sendKnown(g, modelNonSingletons(g), modelSingletonCount(g), name);
    endtask

    // outputs are sampled half a period away from any input change
    always @(negedge clk) begin
        checkResult();
    end

    task automatic checkResult();
        graphMask expMask;
        int expCount;
        int unsigned expCycle;
        string name;
        if (!rstN) begin
            assert (!result.valid) else begin
                $display("result valid went high while reset was asserted");
                stopRun();
            end
        end else if (result.valid) begin
            assert (expNameQ.size() > 0) else begin
                $display("a result came out with no graph pending in test %s", testName);
                stopRun();
            end
            expMask = expMaskQ.pop_front();
            expCount = expCountQ.pop_front();
            expCycle = expCycleQ.pop_front();
            name = expNameQ.pop_front();
            assert (cycleCount == expCycle) else begin
                $display("FAIL %s latency: expected %0d, actual %0d", name, expectedLatency,
                         expectedLatency + int'(cycleCount) - int'(expCycle));
                stopRun();
            end
            assert (result.nonSingletons == expMask) else begin
                $display("FAIL %s nonSingletons: expected %h, actual %h", name, expMask,
                         result.nonSingletons);
                stopRun();
            end
            assert (int'(result.singletonCount) == expCount) else begin
                $display("FAIL %s singletonCount: expected %0d, actual %0d", name, expCount,
                         result.singletonCount);
                stopRun();
            end
        end
    endtask

    // waits until every pending result has been checked, then watches two quiet cycles
    // so that a strobe longer than one cycle shows up as an extra result
    task automatic waitResults();
        int waited;
        waited = 0;
        while (expNameQ.size() > 0 && waited < resultTimeout) begin
            @(posedge clk);
            waited++;
        end
        assert (expNameQ.size() == 0) else begin
            $display("no result arrived in test %s within %0d cycles", testName, resultTimeout);
            stopRun();
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic testEmptyFull();
        testName = "emptyFull";
        sendKnown('0, '0, 0, "empty");
        driveIdle();
        waitResults();
        sendKnown('1, '1, 0, "full");
        driveIdle();
        waitResults();
    endtask

    task automatic testIsolated();
        graphMask even;
        graphMask quads;
        testName = "isolated";
        even = '0;
        for (int v = 0; v < vertexCount; v++) begin
            even[v] = ($countones(v) % 2) == 0;
        end
        sendKnown(even, '0, 64, "evenParity");
        driveIdle();
        waitResults();
        // 0, 3, 5 and 6 of a 3-subcube, none of them adjacent
        quads = '0;
        quads[88] = 1'b1;
        quads[91] = 1'b1;
        quads[93] = 1'b1;
        quads[94] = 1'b1;
        sendKnown(quads, '0, 4, "oneSubcube");
        driveIdle();
        waitResults();
    endtask

    task automatic testMixed();
        graphMask pairs;
        graphMask lone;
        testName = "mixed";
        // 10-11 is a pair, 40-44-36-100 is a chain
        pairs = '0;
        pairs[10] = 1'b1;
        pairs[11] = 1'b1;
        pairs[36] = 1'b1;
        pairs[40] = 1'b1;
        pairs[44] = 1'b1;
        pairs[100] = 1'b1;
        lone = '0;
        lone[0] = 1'b1;
        lone[85] = 1'b1;
        lone[127] = 1'b1;
        sendKnown(pairs | lone, pairs, 3, "pairsAndLone");
        driveIdle();
        waitResults();
        sendGraph(randomGraph(), "mixedRandom");
        driveIdle();
        waitResults();
    endtask

    // beats follow without a gap, so a new graph starts every four cycles
    task automatic testBackToBack();
        testName = "backToBack";
        for (int i = 0; i < 8; i++) begin
            sendGraph(randomGraph(), $sformatf("backToBack%0d", i));
        end
        driveIdle();
        waitResults();
    endtask

    task automatic testFraming();
        testName = "framing";
        // a whole graph's worth of stray beats before the graph and another after it
        // would complete a graph if taken in, and that extra result gets flagged
        for (int i = 0; i < wordsPerGraph; i++) begin
            driveBeat(32'hffffffff, 1'b0);
        end
        sendGraph(randomGraph(), "strayAround");
        for (int i = 0; i < wordsPerGraph; i++) begin
            driveBeat(32'hffffffff, 1'b0);
        end
        driveIdle();
        waitResults();
        // the second wordFirst throws the two half-sent beats away
        driveBeat(32'h0000000f, 1'b1);
        driveBeat(32'hf0f0f0f0, 1'b0);
        sendGraph(randomGraph(), "restart");
        driveIdle();
        waitResults();
    endtask

    task automatic testReset();
        testName = "reset";
        // the graph in flight is lost, so nothing is expected for it
        sendBeats(randomGraph());
        driveIdle();
        driveIdle();
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        #driveDelay;
        rstN = 1'b1;
        // the monitor flags any strobe while the pipeline drains
        repeat (12) @(posedge clk);
        sendGraph(randomGraph(), "afterReset");
        driveIdle();
        waitResults();
    endtask

    initial begin
        void'($urandom(32'hdcd));
        rstN = 1'b0;
        wordIn = '0;
        wordValid = 1'b0;
        wordFirst = 1'b0;
        cycleCount = 0;
        testName = "powerOn";
        repeat (5) @(posedge clk);
        #driveDelay;
        rstN = 1'b1;

        testEmptyFull();
        testIsolated();
        testMixed();
        testBackToBack();
        testFraming();
        testReset();

        if (expNameQ.size() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
source/hypercubePkg.sv
source/graphCapture.sv
source/neighborDetect.sv
source/singletonCounter.sv
source/singletonEliminator.sv
source/resultAlign.sv
source/singletonEliminationTop.sv
tb/singletonElimTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the singleton elimination testbench with Verilator and runs it
# the run counts as failed when the log holds the fail message

cd "$(dirname "$0")" || exit 1

logFile=sim.log
simBinary=singletonElimSim

verilator --binary --timing --assert -Wno-fatal \
    -f build.f \
    --top-module singletonElimTb \
    -o "$simBinary"
if [ $? -ne 0 ]; then
    echo "Verilator build did not succeed"
    exit 1
fi

./obj_dir/"$simBinary" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Checks failed" "$logFile"; then
    exit 1
fi

if [ $simStatus -ne 0 ]; then
    echo "simulation ended with status $simStatus"
    exit 1
fi

if ! grep -q "All checks passed" "$logFile"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0
